// ==== sim.f ====
source/soc_pkg.sv
source/mem_bus_if.sv
source/byte_lane_ram.sv
source/ram_bank_array.sv
source/gpio_regs.sv
source/bus_decoder.sv
source/soc_mem_top.sv
bench/tb_clock_gen.sv
bench/soc_mem_tb.sv

// ==== bench/soc_mem_tb.sv ====
`timescale 1ns/10ps

module soc_mem_tb;
  import soc_pkg::*;

  localparam int    NUM_BANKS = 4;
  localparam int    TIMEOUT   = 64;
  localparam int    RAM_WORDS = 24;
  localparam int    PARTIALS  = 16;
  // region bases, from the memory map
  localparam addr_t TEXT_BASE = 32'h0000_0000;
  localparam addr_t HEAP_BASE = 32'h0001_0000;
  localparam addr_t GPIO_BASE = 32'h8001_0000;
  localparam addr_t BAD_ADDR  = 32'h4000_0000;
  // byte offsets of OUT0 and IN0 inside the gpio region
  localparam addr_t OUT_OFS   = 32'h40;
  localparam addr_t IN_OFS    = 32'h50;

  logic              clk;
  logic              resetn;
  logic              mem_valid;
  addr_t             mem_addr;
  word_t             mem_wdata;
  strb_t             mem_wstrb;
  logic              mem_ready;
  word_t             mem_rdata;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;

  // reference model, one word memory per region
  word_t             text_model [int unsigned];
  word_t             heap_model [int unsigned];
  logic [GPIO_W-1:0] out_mirror;
  // written words, bit 16 marks the heap region
  int unsigned       written [$];

  int check_count;
  int error_count;
  int timeout_count;

  tb_clock_gen #(
    .PERIOD (40)
  ) u_clock (
    .clk_o (clk)
  );

  soc_mem_top #(
    .NUM_BANKS (NUM_BANKS)
  ) UUT (
    .clk         (clk),
    .resetn      (resetn),
    .mem_valid_i (mem_valid),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_wstrb_i (mem_wstrb),
    .mem_ready_o (mem_ready),
    .mem_rdata_o (mem_rdata),
    .gpio_in_i   (gpio_in),
    .gpio_out_o  (gpio_out)
  );

  task automatic check_value(input string name, input logic [GPIO_W-1:0] expected,
                             input logic [GPIO_W-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // one master transfer, valid held until ready
  task automatic bus_access(input addr_t addr, input word_t wdata, input strb_t wstrb,
                            output word_t rdata, output bit responded);
    int cycles;
    responded = 1'b0;
    rdata     = '0;
    cycles    = 0;
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= wstrb;
    // sample on the falling edge, away from the drive edge
    while (!responded && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (mem_ready === 1'b1) begin
        responded = 1'b1;
        rdata     = mem_rdata;
      end
    end
    // valid low for the minimum single cycle before the next request
    @(posedge clk);
    mem_valid <= 1'b0;
  endtask

  task automatic mapped_access(input addr_t addr, input word_t wdata, input strb_t wstrb,
                               output word_t rdata);
    bit responded;
    bus_access(addr, wdata, wstrb, rdata, responded);
    if (!responded) begin
      timeout_count++;
      $display("Timeout: no mem_ready_o within %0d cycles for address %h", TIMEOUT, addr);
    end
  endtask

  // bytewise merge under the strobes
  function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
    word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // word aligned offset inside a 64 KB region
  function automatic int unsigned random_offset();
    return $urandom_range(16383, 0) << 2;
  endfunction

  task automatic ram_write(input bit heap, input int unsigned off, input word_t data,
                           input strb_t strb);
    word_t old_word;
    word_t unused;
    if (heap) begin
      old_word        = heap_model.exists(off) ? heap_model[off] : '0;
      heap_model[off] = merge_bytes(old_word, data, strb);
    end else begin
      old_word        = text_model.exists(off) ? text_model[off] : '0;
      text_model[off] = merge_bytes(old_word, data, strb);
    end
    mapped_access((heap ? HEAP_BASE : TEXT_BASE) + off, data, strb, unused);
  endtask

  task automatic ram_read_check(input string name, input bit heap, input int unsigned off);
    word_t expected;
    word_t actual;
    expected = heap ? heap_model[off] : text_model[off];
    mapped_access((heap ? HEAP_BASE : TEXT_BASE) + off, '0, 4'h0, actual);
    check_value($sformatf("%s %s+%04h", name, heap ? "heap" : "text", off), expected, actual);
  endtask

  initial begin
    int unsigned off;
    int unsigned key;
    int          j;
    int          idle;
    bit          heap;
    bit          responded;
    word_t       data;
    word_t       rdata;
    strb_t       strb;
    logic [GPIO_W-1:0] in_value;

    // seed once for the whole run
    void'($urandom(32'h1075));
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    out_mirror    = '0;
    resetn    <= 1'b0;
    mem_valid <= 1'b0;
    mem_addr  <= '0;
    mem_wdata <= '0;
    mem_wstrb <= '0;
    gpio_in   <= '0;
    repeat (16) @(posedge clk);
    resetn <= 1'b1;

    // quiet after reset
    @(negedge clk);
    check_value("gpio_out after reset", '0, gpio_out);
    idle = 0;
    while (idle < 8) begin
      @(negedge clk);
      if (mem_ready !== 1'b0) begin
        error_count++;
        $display("Error: mem_ready_o is not low while no request is made");
      end
      idle++;
    end

    // full words, random region and offset
    for (int i = 0; i < RAM_WORDS; i++) begin
      heap = $urandom_range(1, 0);
      off  = random_offset();
      ram_write(heap, off, $urandom(), 4'hf);
      written.push_back(heap ? off + 32'h1_0000 : off);
    end
    // same offset in both regions, different data
    off = random_offset();
    ram_write(1'b0, off, $urandom(), 4'hf);
    ram_write(1'b1, off, $urandom(), 4'hf);
    written.push_back(off);
    written.push_back(off + 32'h1_0000);

    // shuffle so reads come back in random order
    for (int i = written.size() - 1; i > 0; i--) begin
      j          = $urandom_range(i, 0);
      key        = written[i];
      written[i] = written[j];
      written[j] = key;
    end
    foreach (written[i]) begin
      key = written[i];
      ram_read_check("ram full word", key[16], key[15:0]);
    end

    // partial strobes on words already written
    for (int i = 0; i < PARTIALS; i++) begin
      key  = written[$urandom_range(written.size() - 1, 0)];
      strb = $urandom_range(14, 1);
      ram_write(key[16], key[15:0], $urandom(), strb);
    end
    foreach (written[i]) begin
      key = written[i];
      ram_read_check("ram partial", key[16], key[15:0]);
    end

    // output registers, full words land on the pins
    for (int i = 0; i < 4; i++) begin
      data = $urandom();
      mapped_access(GPIO_BASE + OUT_OFS + 4 * i, data, 4'hf, rdata);
      out_mirror[i*32 +: 32] = data;
      @(negedge clk);
      check_value($sformatf("gpio_out after OUT%0d write", i), out_mirror, gpio_out);
    end
    // partial strobes must not change anything
    for (int i = 0; i < 4; i++) begin
      strb = $urandom_range(14, 1);
      mapped_access(GPIO_BASE + OUT_OFS + 4 * i, $urandom(), strb, rdata);
      @(negedge clk);
      check_value($sformatf("gpio_out after OUT%0d partial", i), out_mirror, gpio_out);
    end
    for (int i = 0; i < 4; i++) begin
      mapped_access(GPIO_BASE + OUT_OFS + 4 * i, '0, 4'h0, rdata);
      check_value($sformatf("OUT%0d read", i), out_mirror[i*32 +: 32], rdata);
    end

    // input read-back
    in_value = {$urandom(), $urandom(), $urandom(), $urandom()};
    @(posedge clk);
    gpio_in <= in_value;
    for (int i = 0; i < 4; i++) begin
      mapped_access(GPIO_BASE + IN_OFS + 4 * i, '0, 4'h0, rdata);
      check_value($sformatf("IN%0d read", i), in_value[i*32 +: 32], rdata);
    end

    // unmapped region never answers
    bus_access(BAD_ADDR, $urandom(), 4'hf, rdata, responded);
    if (responded) begin
      error_count++;
      $display("Error: access to unmapped address %h got a response", BAD_ADDR);
    end
    key = written[0];
    ram_read_check("ram after unmapped", key[16], key[15:0]);

    $display("checks %0d, value errors %0d, timeouts %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  // starts low, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// ==== source/soc_mem_top.sv ====
`timescale 1ns/10ps

module soc_mem_top #(
  parameter int NUM_BANKS = 4
) (
  input  logic                       clk,
  input  logic                       resetn,
  // master request
  input  logic                       mem_valid_i,
  input  soc_pkg::addr_t             mem_addr_i,
  input  soc_pkg::word_t             mem_wdata_i,
  input  soc_pkg::strb_t             mem_wstrb_i,
  // master response
  output logic                       mem_ready_o,
  output soc_pkg::word_t             mem_rdata_o,
  // gpio pins
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o
);

  // one bus per target region
  mem_bus_if text_bus ();
  mem_bus_if heap_bus ();
  mem_bus_if gpio_bus ();

  // registers the request and merges the answers
  bus_decoder u_decoder (
    .clk         (clk),
    .resetn      (resetn),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .text_o      (text_bus),
    .heap_o      (heap_bus),
    .gpio_o      (gpio_bus)
  );

  // region 0x0000, code
  ram_bank_array #(
    .NUM_BANKS (NUM_BANKS)
  ) text_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus_i  (text_bus)
  );

  // region 0x0001, data and stack
  ram_bank_array #(
    .NUM_BANKS (NUM_BANKS)
  ) heap_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus_i  (heap_bus)
  );

  // region 0x8001, pin registers
  gpio_regs u_gpio (
    .clk        (clk),
    .resetn     (resetn),
    .bus_i      (gpio_bus),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o)
  );

endmodule

// ==== source/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder (
  input  logic           clk,
  input  logic           resetn,
  // master port
  input  logic           mem_valid_i,
  input  soc_pkg::addr_t mem_addr_i,
  input  soc_pkg::word_t mem_wdata_i,
  input  soc_pkg::strb_t mem_wstrb_i,
  output logic           mem_ready_o,
  output soc_pkg::word_t mem_rdata_o,
  // one bus per target
  mem_bus_if.initiator   text_o,
  mem_bus_if.initiator   heap_o,
  mem_bus_if.initiator   gpio_o
);
  import soc_pkg::*;

  region_t region;
  target_e tgt_d;
  target_e tgt_q;
  logic    rsp_ready;
  word_t   rsp_rdata;

  // region code is the upper address half
  assign region = mem_addr_i[$bits(addr_t)-1:REGION_OFFSET_BITS];

  // pick the target for the current request
  always_comb begin
    tgt_d = TGT_NONE;
    if (mem_valid_i) begin
      case (region)
        REGION_TEXT: tgt_d = TGT_TEXT;
        REGION_HEAP: tgt_d = TGT_HEAP;
        REGION_GPIO: tgt_d = TGT_GPIO;
        // unmapped, nobody answers
        default:     tgt_d = TGT_NONE;
      endcase
    end
  end

  // request fields go to every target each cycle
  always_ff @(posedge clk) begin
    text_o.addr  <= mem_addr_i;
    text_o.wdata <= mem_wdata_i;
    text_o.wstrb <= mem_wstrb_i;
    heap_o.addr  <= mem_addr_i;
    heap_o.wdata <= mem_wdata_i;
    heap_o.wstrb <= mem_wstrb_i;
    gpio_o.addr  <= mem_addr_i;
    gpio_o.wdata <= mem_wdata_i;
    gpio_o.wstrb <= mem_wstrb_i;
  end

  // only the matching target sees valid
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tgt_q        <= TGT_NONE;
      text_o.valid <= 1'b0;
      heap_o.valid <= 1'b0;
      gpio_o.valid <= 1'b0;
      mem_ready_o  <= 1'b0;
    end else begin
      tgt_q        <= tgt_d;
      text_o.valid <= (tgt_d == TGT_TEXT);
      heap_o.valid <= (tgt_d == TGT_HEAP);
      gpio_o.valid <= (tgt_d == TGT_GPIO);
      // one more stage toward the master
      mem_ready_o  <= rsp_ready;
    end
  end

  // response merge, taken from the active target only
  always_comb begin
    rsp_ready = 1'b0;
    rsp_rdata = '0;
    case (tgt_q)
      TGT_TEXT: begin
        rsp_ready = text_o.ready;
        rsp_rdata = text_o.rdata;
      end
      TGT_HEAP: begin
        rsp_ready = heap_o.ready;
        rsp_rdata = heap_o.rdata;
      end
      TGT_GPIO: begin
        rsp_ready = gpio_o.ready;
        rsp_rdata = gpio_o.rdata;
      end
      default: begin
        rsp_ready = 1'b0;
        rsp_rdata = '0;
      end
    endcase
  end

  // read data travels with mem_ready_o
  always_ff @(posedge clk) begin
    mem_rdata_o <= rsp_rdata;
  end

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/10ps

module gpio_regs (
  input  logic                       clk,
  input  logic                       resetn,
  mem_bus_if.target                  bus_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o
);
  import soc_pkg::*;

  localparam int WORD_W = $bits(word_t);

  gpio_reg_e  reg_sel;
  logic [1:0] slot;
  logic       valid_q;
  logic       start;

  // word offset inside the region
  assign reg_sel = gpio_reg_e'(bus_i.addr[7:2]);
  // which 32 bit slice of the vector
  assign slot    = bus_i.addr[3:2];
  // access starts on the valid rise only
  assign start   = bus_i.valid && !valid_q;

  // control side, ready pulse and the output registers
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q     <= 1'b0;
      bus_i.ready <= 1'b0;
      gpio_out_o  <= '0;
    end else begin
      valid_q     <= bus_i.valid;
      // every offset answers, mapped or not
      bus_i.ready <= start;
      // full word writes only
      if (start && (bus_i.wstrb == '1)) begin
        case (reg_sel)
          OUT0, OUT1, OUT2, OUT3: begin
            gpio_out_o[slot*WORD_W +: WORD_W] <= bus_i.wdata;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // read data
  // out registers give the value before a write lands
  always_ff @(posedge clk) begin
    if (start) begin
      case (reg_sel)
        OUT0, OUT1, OUT2, OUT3: begin
          bus_i.rdata <= gpio_out_o[slot*WORD_W +: WORD_W];
        end
        IN0, IN1, IN2, IN3: begin
          bus_i.rdata <= gpio_in_i[slot*WORD_W +: WORD_W];
        end
        // other offsets keep the last word
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== source/ram_bank_array.sv ====
`timescale 1ns/10ps

module ram_bank_array #(
  parameter int NUM_BANKS = 4
) (
  input  logic      clk,
  input  logic      resetn,
  mem_bus_if.target bus_i
);
  import soc_pkg::*;

  // word address bits inside the 64 KB region
  localparam int WORD_BITS = REGION_OFFSET_BITS - 2;
  localparam int WORDS     = (1 << WORD_BITS) / NUM_BANKS;
  localparam int INDEX_W   = $clog2(WORDS);
  // keep the select one bit wide for a single bank
  localparam int SEL_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [WORD_BITS-1:0] word_addr;
  logic [INDEX_W-1:0]   word_idx;
  logic [SEL_W-1:0]     bank_sel;
  logic [SEL_W-1:0]     sel_q1;
  logic [SEL_W-1:0]     sel_q2;
  strb_t                wstrb_s1 [NUM_BANKS];
  strb_t                wstrb_s2 [NUM_BANKS];
  word_t                bank_rdata [NUM_BANKS];
  word_t                bank_rdata_q [NUM_BANKS];
  logic                 valid_q;
  logic                 ready_s1;
  logic                 ready_s2;

  // upper word bits pick the bank, the rest index into it
  assign word_addr = bus_i.addr[REGION_OFFSET_BITS-1:2];
  assign word_idx  = word_addr[INDEX_W-1:0];
  assign bank_sel  = SEL_W'(word_addr >> INDEX_W);

  // write strobe pipeline
  // stage 1 steers the strobes to the selected bank
  // stage 2 lets them through only while valid was seen and still holds
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        wstrb_s1[b] <= '0;
        wstrb_s2[b] <= '0;
      end
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        wstrb_s1[b] <= (bank_sel == SEL_W'(b)) ? bus_i.wstrb : '0;
        wstrb_s2[b] <= (valid_q && bus_i.valid) ? wstrb_s1[b] : '0;
      end
    end
  end

  // the banks, all on the same word index
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    byte_lane_ram #(
      .WORDS (WORDS)
    ) u_bank (
      .clk     (clk),
      .addr_i  (word_idx),
      .wdata_i (bus_i.wdata),
      .wstrb_i (wstrb_s2[b]),
      .en_i    (bus_i.valid),
      .rdata_o (bank_rdata[b])
    );
  end

  // read path
  // bank output register, then mux on the bank index two cycles late
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_rdata_q[b] <= bank_rdata[b];
    end
    sel_q1      <= bank_sel;
    sel_q2      <= sel_q1;
    bus_i.rdata <= bank_rdata_q[sel_q2];
  end

  // ready pulse, started by the valid rise only
  // write answers off stage 1, read off stage 2
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q     <= 1'b0;
      ready_s1    <= 1'b0;
      ready_s2    <= 1'b0;
      bus_i.ready <= 1'b0;
    end else begin
      valid_q     <= bus_i.valid;
      ready_s1    <= bus_i.valid && !valid_q;
      ready_s2    <= ready_s1;
      bus_i.ready <= (|bus_i.wstrb) ? ready_s1 : ready_s2;
    end
  end

endmodule

// ==== source/byte_lane_ram.sv ====
`timescale 1ns/10ps

module byte_lane_ram #(
  parameter int WORDS = 4096
) (
  input  logic                     clk,
  input  logic [$clog2(WORDS)-1:0] addr_i,
  input  soc_pkg::word_t           wdata_i,
  input  soc_pkg::strb_t           wstrb_i,
  input  logic                     en_i,
  output soc_pkg::word_t           rdata_o
);
  import soc_pkg::*;

  // one byte lane per strobe bit
  localparam int LANES = $bits(strb_t);
  localparam int LANE_W = $bits(word_t) / LANES;

  word_t mem [WORDS];

  // write first per lane
  // a written byte shows up on the output with the new value
  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (wstrb_i[i]) begin
          mem[addr_i][i*LANE_W +: LANE_W] <= wdata_i[i*LANE_W +: LANE_W];
          rdata_o[i*LANE_W +: LANE_W]     <= wdata_i[i*LANE_W +: LANE_W];
        end else begin
          // untouched lane reads the stored byte
          rdata_o[i*LANE_W +: LANE_W] <= mem[addr_i][i*LANE_W +: LANE_W];
        end
      end
    end
  end

endmodule

// ==== source/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if;
  import soc_pkg::*;

  // request side, held stable until ready
  logic  valid;
  addr_t addr;
  word_t wdata;
  strb_t wstrb;

  // response side
  // ready is a single cycle pulse per access
  logic  ready;
  word_t rdata;

  // decoder side
  modport initiator (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  // memory or register block side
  modport target (
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

// ==== source/soc_pkg.sv ====
package soc_pkg;

  // bus field types, shared by the decoder, the targets and the top
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // one bit per byte lane, all zero is a read
  typedef logic [3:0]  strb_t;

  // upper address half picks the region
  typedef logic [15:0] region_t;

  // byte offset inside one region, 64 KB
  localparam int REGION_OFFSET_BITS = 16;

  // region codes
  localparam region_t REGION_TEXT = 16'h0000;
  localparam region_t REGION_HEAP = 16'h0001;
  localparam region_t REGION_GPIO = 16'h8001;

  // target currently owning the request
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_TEXT,
    TGT_HEAP,
    TGT_GPIO
  } target_e;

  // width of the gpio in and out vectors
  localparam int GPIO_W = 128;

  // gpio word registers, by word offset addr[7:2]
  typedef enum logic [5:0] {
    OUT0 = 6'h10,
    OUT1 = 6'h11,
    OUT2 = 6'h12,
    OUT3 = 6'h13,
    // input read-back, writes ignored
    IN0  = 6'h14,
    IN1  = 6'h15,
    IN2  = 6'h16,
    IN3  = 6'h17
  } gpio_reg_e;

endpackage
